// ==== verilog/arb_pkg.sv ====
`default_nettype none

package arb_pkg;

  // upstream side
  localparam int NUM_IN = 4;
  localparam int SRC_W  = $clog2(NUM_IN);  // source index carried with each word
  localparam int DATA_W = 16;

  // output fifo
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);  // count has to reach FIFO_DEPTH

  // one upstream payload word
  typedef logic [DATA_W-1:0] data_t;

  // what the arbiter writes into the fifo
  // src sits above data so the tag is in the top bits of the stored word
  typedef struct packed {
    logic [SRC_W-1:0] src;   // index of the input the word came from
    data_t            data;
  } arb_word_t;

endpackage : arb_pkg

`default_nettype wire

// ==== verilog/skid_buf.sv ====
`timescale 1ns/100ps
`default_nettype none

module skid_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,

  // upstream side
  input  logic     valid_us,
  output logic     stall_us,
  input  payload_t data_us,

  // downstream side
  output logic     valid_ds,
  input  logic     stall_ds,
  output payload_t data_ds
);

  logic     hold_valid;    // holding register occupied
  payload_t hold_data;     // word parked while downstream stalls
  logic     capture;       // live word blocked this cycle
  logic     drain;         // held word leaves at this edge

  // a live word only gets parked when nothing is held yet
  assign capture = valid_us & ~hold_valid & stall_ds;
  assign drain   = hold_valid & ~stall_ds;

  // held word goes out first, otherwise the live input passes straight through
  assign valid_ds = hold_valid | valid_us;
  assign data_ds  = hold_valid ? hold_data : data_us;

  // stall toward upstream is the flag flop itself, so it is registered
  assign stall_us = hold_valid;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hold_valid <= 1'b0;
    end else if (capture) begin
      hold_valid <= 1'b1;
    end else if (drain) begin
      hold_valid <= 1'b0;   // upstream word, if any, flows through next cycle
    end
  end

  // payload only moves on capture
  always_ff @(posedge clk) begin
    if (capture) begin
      hold_data <= data_us;
    end
  end

endmodule : skid_buf

`default_nettype wire

// ==== verilog/rr_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter import arb_pkg::*; (
  input  logic               clk,
  input  logic               rst,

  // buffered inputs, one bit or word per source
  input  logic [NUM_IN-1:0]  req,
  input  data_t [NUM_IN-1:0] req_data,
  output logic [NUM_IN-1:0]  req_stall,

  // fifo write port
  input  logic               fifo_full,
  output logic               wr_en,
  output arb_word_t          wr_word
);

  logic [SRC_W-1:0]  ptr;        // input with top priority this cycle
  logic [SRC_W-1:0]  ptr_next;
  logic [SRC_W-1:0]  sel;        // first requester found from ptr upward
  logic              found;
  logic [NUM_IN-1:0] grant;      // one-hot, all zero when nothing is written

  // search order is ptr, ptr+1, ... wrapping at NUM_IN
  always_comb begin
    int idx;
    sel   = ptr;
    found = 1'b0;
    for (int i = 0; i < NUM_IN; i++) begin
      idx = int'(ptr) + i;
      if (idx >= NUM_IN) begin
        idx = idx - NUM_IN;
      end
      if (!found && req[idx]) begin
        found = 1'b1;
        sel   = SRC_W'(idx);
      end
    end
  end

  // no grant at all while the fifo is full, so a write is never lost
  assign wr_en = found & ~fifo_full;
  assign grant = wr_en ? (NUM_IN'(1) << sel) : '0;

  // losers hold their word, and everyone holds while the fifo is full
  assign req_stall = fifo_full ? '1 : (req & ~grant);

  // tag the winning word with its source
  assign wr_word.src  = sel;
  assign wr_word.data = req_data[sel];

  // pointer steps by one after every grant, whoever won
  assign ptr_next = (ptr == SRC_W'(NUM_IN - 1)) ? '0 : ptr + 1'b1;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ptr <= '0;
    end else if (wr_en) begin
      ptr <= ptr_next;
    end
  end

endmodule : rr_arbiter

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module sync_fifo import arb_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,

  // write side
  input  logic     wr_en,
  input  payload_t wr_data,
  output logic     full,

  // read side, valid/stall
  output logic     valid_ds,
  input  logic     stall_ds,
  output payload_t rd_data
);

  payload_t              mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;    // words currently stored
  logic                  empty;
  logic                  rd_en;
  logic                  wr_ok;

  // circular pointer step
  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] p);
    return (p == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty    = (count == '0);
  assign full     = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign valid_ds = ~empty;
  assign rd_en    = valid_ds & ~stall_ds;

  // a read at the same edge frees a slot, so full alone does not block the write
  assign wr_ok = wr_en & (~full | rd_en);

  assign rd_data = mem[rd_ptr];   // head of queue, visible the cycle after the write

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_ok, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // idle, or read and write together
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule : sync_fifo

`default_nettype wire

// ==== verilog/arb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module arb_top import arb_pkg::*; (
  input  logic               clk,
  input  logic               rst,

  // upstream streams
  input  logic [NUM_IN-1:0]  valid_us,
  output logic [NUM_IN-1:0]  stall_us,
  input  data_t [NUM_IN-1:0] data_us,

  // merged downstream stream
  output logic               valid_ds,
  input  logic               stall_ds,
  output data_t              data_ds,
  output logic [SRC_W-1:0]   src_ds
);

  // skid buffer outputs toward the arbiter
  logic [NUM_IN-1:0]  buf_valid;
  logic [NUM_IN-1:0]  buf_stall;
  data_t [NUM_IN-1:0] buf_data;

  // arbiter to fifo
  logic               fifo_full;
  logic               fifo_wr_en;
  arb_word_t          fifo_wr_word;
  arb_word_t          fifo_rd_word;

  // one skid buffer per input so each stall_us comes from a flop
  generate
    for (genvar i = 0; i < NUM_IN; i++) begin : in_buf
      skid_buf #(.payload_t(data_t)) u_skid (
        .clk,
        .rst,
        .valid_us (valid_us[i]),
        .stall_us (stall_us[i]),
        .data_us  (data_us[i]),
        .valid_ds (buf_valid[i]),
        .stall_ds (buf_stall[i]),
        .data_ds  (buf_data[i])
      );
    end
  endgenerate

  rr_arbiter u_arb (
    .clk,
    .rst,
    .req       (buf_valid),
    .req_data  (buf_data),
    .req_stall (buf_stall),
    .fifo_full (fifo_full),
    .wr_en     (fifo_wr_en),
    .wr_word   (fifo_wr_word)
  );

  sync_fifo #(.payload_t(arb_word_t)) u_fifo (
    .clk,
    .rst,
    .wr_en    (fifo_wr_en),
    .wr_data  (fifo_wr_word),
    .full     (fifo_full),
    .valid_ds (valid_ds),
    .stall_ds (stall_ds),
    .rd_data  (fifo_rd_word)
  );

  // split the tagged word back into payload and source index
  assign data_ds = fifo_rd_word.data;
  assign src_ds  = fifo_rd_word.src;

endmodule : arb_top

`default_nettype wire

// ==== testbench/tb_arb_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module arb_handshake_assert import arb_pkg::*; (
  input logic              clk,
  input logic              rst,
  input logic              valid_ds,
  input logic              stall_ds,
  input data_t             data_ds,
  input logic [SRC_W-1:0]  src_ds,
  input logic [NUM_IN-1:0] stall_us,
  input logic              fifo_full,
  input logic              wr_en
);

  // a stalled word stays on the downstream port unchanged
  property hold_under_stall;
    @(posedge clk) disable iff (rst)
      (valid_ds && stall_ds) |=> (valid_ds && $stable(data_ds) && $stable(src_ds));
  endproperty

  // skid buffers are empty while reset is held
  property quiet_in_reset;
    @(posedge clk) (rst && $past(rst)) |-> (stall_us == '0);
  endproperty

  property no_write_when_full;
    @(posedge clk) disable iff (rst) !(fifo_full && wr_en);
  endproperty

  hold_chk: assert property (hold_under_stall)
    else $error("downstream word changed while stall_ds was high");

  reset_chk: assert property (quiet_in_reset)
    else $error("stall_us high during reset");

  full_chk: assert property (no_write_when_full)
    else $error("fifo written while full");

endmodule : arb_handshake_assert

bind arb_top arb_handshake_assert u_handshake_chk (
  .clk       (clk),
  .rst       (rst),
  .valid_ds  (valid_ds),
  .stall_ds  (stall_ds),
  .data_ds   (data_ds),
  .src_ds    (src_ds),
  .stall_us  (stall_us),
  .fifo_full (fifo_full),
  .wr_en     (fifo_wr_en)
);

`default_nettype wire

// ==== testbench/tb_arb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_arb_top import arb_pkg::*; ();

  logic               clk;
  logic               rst;
  logic [NUM_IN-1:0]  valid_us;
  logic [NUM_IN-1:0]  stall_us;
  data_t [NUM_IN-1:0] data_us;
  logic               valid_ds;
  logic               stall_ds;
  data_t              data_ds;
  logic [SRC_W-1:0]   src_ds;

  // reference model with one queue of expected words per source
  data_t                   exp_q [NUM_IN][$];
  data_t                   exp_word;
  int                      acc_cnt [NUM_IN];
  int                      out_cnt [NUM_IN];
  int                      total_out;        // every word ever read is one grant
  logic [NUM_IN-1:0]       blocked;          // valid and stalled just before the edge
  logic                    prev_valid;
  logic                    prev_stall;
  logic [SRC_W+DATA_W-1:0] prev_word;
  logic                    log_src;
  logic [SRC_W-1:0]        src_log [$];

  string       cur_test;
  int          test_err;
  int          err_total;
  int          tests_run;
  int          tests_failed;
  logic        aborted;
  logic [31:0] rng_state;

  arb_top dut_i (
    .clk      (clk),
    .rst      (rst),
    .valid_us (valid_us),
    .stall_us (stall_us),
    .data_us  (data_us),
    .valid_ds (valid_ds),
    .stall_ds (stall_ds),
    .data_ds  (data_ds),
    .src_ds   (src_ds)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %s: %s expected %0h actual %0h", cur_test, what, exp, act);
    test_err++;
    err_total++;
  endtask

  task automatic fail_note(input string msg);
    $display("%s: %s", cur_test, msg);
    test_err++;
    err_total++;
  endtask

  // sampled mid-cycle once everything has settled before the next edge
  always @(negedge clk) begin
    if (rst) begin
      prev_valid = 1'b0;
      prev_stall = 1'b0;
    end else begin
      if (prev_valid && prev_stall) begin
        if (!valid_ds) begin
          fail_note("valid_ds dropped while the word was stalled");
        end else if ({src_ds, data_ds} !== prev_word) begin
          value_error("word held under stall", 32'(prev_word), 32'({src_ds, data_ds}));
        end
      end
      if (valid_ds && !stall_ds) begin
        if (exp_q[src_ds].size() == 0) begin
          fail_note($sformatf("unexpected word %0h from source %0d", data_ds, src_ds));
        end else begin
          exp_word = exp_q[src_ds].pop_front();
          if (exp_word !== data_ds) begin
            value_error($sformatf("data from source %0d", src_ds), 32'(exp_word),
                        32'(data_ds));
          end
        end
        out_cnt[src_ds]++;
        total_out++;
        if (log_src) begin
          src_log.push_back(src_ds);
        end
      end
      for (int i = 0; i < NUM_IN; i++) begin
        if (valid_us[i] && !stall_us[i]) begin
          exp_q[i].push_back(data_us[i]);   // taken at the coming edge
          acc_cnt[i]++;
        end
      end
      blocked    = valid_us & stall_us;
      prev_valid = valid_ds;
      prev_stall = stall_ds;
      prev_word  = {src_ds, data_ds};
    end
  end

  // one cycle of stimulus in which stalled senders keep their word
  task automatic drive_cycle(input logic [NUM_IN-1:0] en_mask, input int valid_pct,
                             input int stall_pct);
    @(posedge clk);
    #2;
    for (int i = 0; i < NUM_IN; i++) begin
      if (!blocked[i]) begin
        valid_us[i] = en_mask[i] && (int'(next_rand() % 32'd100) < valid_pct);
        data_us[i]  = data_t'(next_rand());
      end
    end
    stall_ds = int'(next_rand() % 32'd100) < stall_pct;
  endtask

  task automatic drain();
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n < 200) begin
      drive_cycle('0, 0, 0);
      @(negedge clk);
      if (valid_us == '0 && !valid_ds && stall_us == '0) begin
        done = 1'b1;
      end
      n++;
    end
    if (!done) begin
      fail_note("timed out waiting for the outputs to drain");
      aborted = 1'b1;
    end
  endtask

  task automatic check_drained();
    for (int i = 0; i < NUM_IN; i++) begin
      if (exp_q[i].size() != 0) begin
        value_error($sformatf("words left for source %0d", i), 0, 32'(exp_q[i].size()));
      end
      if (out_cnt[i] != acc_cnt[i]) begin
        value_error($sformatf("word count of source %0d", i), 32'(acc_cnt[i]),
                    32'(out_cnt[i]));
      end
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err = 0;
    for (int i = 0; i < NUM_IN; i++) begin
      acc_cnt[i] = 0;
      out_cnt[i] = 0;
    end
  endtask

  task automatic end_test();
    tests_run++;
    if (test_err == 0) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_err);
    end
  endtask

  task automatic reset_values();
    begin_test("reset");
    @(negedge clk);
    if (valid_ds !== 1'b0) value_error("valid_ds", 0, 32'(valid_ds));
    if (stall_us !== '0) value_error("stall_us", 0, 32'(stall_us));
    repeat (3) drive_cycle('0, 0, 0);
    @(negedge clk);
    if (valid_ds !== 1'b0) value_error("valid_ds when idle", 0, 32'(valid_ds));
    end_test();
  endtask

  task automatic single_source();
    int                src;
    logic [NUM_IN-1:0] mask;
    begin_test("single_source");
    src       = int'(next_rand() % 32'(NUM_IN));
    mask      = '0;
    mask[src] = 1'b1;
    repeat (80) drive_cycle(mask, 60, 0);
    drain();
    for (int i = 0; i < NUM_IN; i++) begin
      if (i != src && out_cnt[i] != 0) begin
        value_error($sformatf("words from idle source %0d", i), 0, 32'(out_cnt[i]));
      end
    end
    if (acc_cnt[src] == 0) fail_note("the active source sent no word");
    check_drained();
    end_test();
  endtask

  task automatic random_traffic();
    begin_test("random_traffic");
    repeat (400) drive_cycle('1, 50, 30);
    drain();
    check_drained();
    end_test();
  endtask

  task automatic fairness_order();
    int start_src;
    int exp_src;
    begin_test("fairness");
    start_src = total_out % NUM_IN;   // pointer moved once per grant since reset
    src_log.delete();
    log_src = 1'b1;
    repeat (40) drive_cycle('1, 100, 0);
    log_src = 1'b0;
    drain();
    if (src_log.size() < 30) fail_note("too few words came out under full load");
    exp_src = start_src;
    foreach (src_log[n]) begin
      if (int'(src_log[n]) != exp_src) begin
        value_error($sformatf("src_ds of word %0d", n), 32'(exp_src), 32'(src_log[n]));
      end
      exp_src = (exp_src == NUM_IN - 1) ? 0 : exp_src + 1;
    end
    check_drained();
    end_test();
  endtask

  task automatic back_pressure();
    int n;
    begin_test("back_pressure");
    n = 0;
    drive_cycle('1, 100, 100);
    while (stall_us != '1 && n < 50) begin
      drive_cycle('1, 100, 100);
      n++;
    end
    if (stall_us != '1) begin
      value_error("stall_us under back-pressure", 32'({NUM_IN{1'b1}}), 32'(stall_us));
    end
    repeat (20) drive_cycle('1, 100, 100);
    @(negedge clk);
    if (valid_ds !== 1'b1) value_error("valid_ds while stalled", 1, 32'(valid_ds));
    repeat (150) drive_cycle('1, 50, 30);
    drain();
    check_drained();
    end_test();
  endtask

  initial begin
    rst          = 1'b1;
    valid_us     = '0;
    data_us      = '0;
    stall_ds     = 1'b0;
    blocked      = '0;
    log_src      = 1'b0;
    total_out    = 0;
    err_total    = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    rng_state    = 32'd25;
    cur_test     = "startup";
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    reset_values();
    if (!aborted) single_source();
    if (!aborted) random_traffic();
    if (!aborted) fairness_order();
    if (!aborted) back_pressure();
    $display("%0d tests run, %0d failed, %0d errors, %0d words checked",
             tests_run, tests_failed, err_total, total_out);
    if (err_total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_arb_top

`default_nettype wire

// ==== sources.f ====
verilog/arb_pkg.sv
verilog/skid_buf.sv
verilog/rr_arbiter.sv
verilog/sync_fifo.sv
verilog/arb_top.sv
testbench/tb_arb_assert.sv
testbench/tb_arb_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_arb_top
RTL_TOP    := arb_top
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := ERRORS FOUND
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
